/* tb.f */
common/adc_pkg.sv
common/capture_pkg.sv
src/adc_if.sv
capture/capture_unit.sv
capture/mem_arbiter.sv
src/sample_ram.sv
src/adc_capture_top.sv
dv/tb_adc_capture.sv

/* Bender.yml */
package:
  name: adc_capture

sources:
  # Packages first, then RTL bottom-up
  - common/adc_pkg.sv
  - common/capture_pkg.sv
  - src/adc_if.sv
  - capture/capture_unit.sv
  - capture/mem_arbiter.sv
  - src/sample_ram.sv
  - src/adc_capture_top.sv
  - target: simulation
    files:
      - dv/tb_adc_capture.sv

/* dv/tb_adc_capture.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ADC capture testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_adc_capture;

  localparam int FW    = adc_pkg::FRAME_WIDTH;
  localparam int AW    = capture_pkg::ADDR_WIDTH;
  localparam int WORDS = capture_pkg::CAPTURE_WORDS;

  // Table holds a slow run, an overflow burst, link-reset frames and a recovery run
  localparam int STORE_FIRST   = 0;
  localparam int BURST_FIRST   = STORE_FIRST + WORDS;
  localparam int BURST_LEN     = 64;
  localparam int LINKRST_FIRST = BURST_FIRST + BURST_LEN;
  localparam int LINKRST_LEN   = WORDS;
  localparam int RECOVER_FIRST = LINKRST_FIRST + LINKRST_LEN;
  localparam int TABLE_LEN     = RECOVER_FIRST + WORDS;
  localparam int SLOW_GAP      = 16;

  // Worst case per frame is its gap plus one handshake for each unit
  localparam int HS_CYCLES   = 6;
  localparam int CYCLE_LIMIT = TABLE_LEN * (SLOW_GAP + 1 + 2 * HS_CYCLES) + 500;

  logic                               rx_clk;
  logic                               rst_n;
  logic                               adc_rst;
  logic                               rx_valid;
  logic [adc_pkg::RX_WIDTH-1:0]       rx_data;
  logic                               arm_a;
  logic                               arm_b;
  logic [AW-1:0]                      rd_addr;
  logic                               adc_status;
  logic                               done_a;
  logic                               done_b;
  logic [capture_pkg::OVF_WIDTH-1:0]  overflow_a;
  logic [capture_pkg::OVF_WIDTH-1:0]  overflow_b;
  logic [FW-1:0]                      rd_data;

  // Stimulus and expected frames
  int                                 gap_tab  [TABLE_LEN];
  logic [adc_pkg::RX_WIDTH-1:0]       word_tab [TABLE_LEN];
  logic [FW-1:0]                      exp_a    [TABLE_LEN];
  logic [FW-1:0]                      exp_b    [TABLE_LEN];

  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  bit          armed_a     = 1'b0;
  bit          armed_b     = 1'b0;
  int          offered_a   = 0;
  int          offered_b   = 0;
  logic [15:0] lfsr;

  adc_capture_top u_adc_capture_top (
    .rx_clk     (rx_clk),
    .rst_n      (rst_n),
    .adc_rst    (adc_rst),
    .rx_valid   (rx_valid),
    .rx_data    (rx_data),
    .arm_a      (arm_a),
    .arm_b      (arm_b),
    .rd_addr    (rd_addr),
    .adc_status (adc_status),
    .done_a     (done_a),
    .done_b     (done_b),
    .overflow_a (overflow_a),
    .overflow_b (overflow_b),
    .rd_data    (rd_data)
  );

  initial rx_clk = 1'b0;

  always #20 rx_clk = ~rx_clk;

  always @(posedge rx_clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_count >= CYCLE_LIMIT);
    $display("Run timed out after %0d cycles before the tests finished", cycle_count);
    $display("** FAIL **");
    $finish;
  end

  // 16-bit Galois LFSR stepped once per bit taken
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Eight high bits from the low half, six low bits from the top of the matching byte
  function automatic logic [FW-1:0] slice_channel(input logic [127:0] word, input int ch);
    logic [63:0]   group;
    logic [31:0]   lo_half;
    logic [31:0]   hi_half;
    logic [13:0]   sample;
    logic [FW-1:0] frame;
    group   = word[ch*64 +: 64];
    lo_half = group[31:0];
    hi_half = group[63:32];
    frame   = '0;
    // Shift in from the top so sample 3 ends up most significant
    for (int s = 0; s < 4; s++) begin
      sample = {lo_half[s*8 +: 8], hi_half[s*8+2 +: 6]};
      frame  = {sample, frame[FW-1:14]};
    end
    return frame;
  endfunction

  task automatic build_table();
    lfsr = 16'd78;
    for (int i = 0; i < TABLE_LEN; i++) begin
      gap_tab[i] = (i >= BURST_FIRST && i < LINKRST_FIRST) ? 0 : SLOW_GAP;
      for (int b = 0; b < adc_pkg::RX_WIDTH; b++) begin
        word_tab[i][b] = lfsr[0];
        lfsr = lfsr_next(lfsr);
      end
      exp_a[i] = slice_channel(word_tab[i], 0);
      exp_b[i] = slice_channel(word_tab[i], 1);
    end
  endtask

  // Advance to the next falling edge and count frames offered to armed units
  task automatic step_cycle();
    @(negedge rx_clk);
    // Word taken at the last rising edge reaches the units at the next one
    if (rx_valid && !adc_rst) begin
      if (armed_a && !done_a) begin
        offered_a++;
      end
      if (armed_b && !done_b) begin
        offered_b++;
      end
    end
  endtask

  task automatic compare_flag(input string what, input int expected, input int actual);
    check_count++;
    if (actual != expected) begin
      error_count++;
      $display("** Error at %0t: %s expected %0d got %0d", $time, what, expected, actual);
    end
  endtask

  task automatic compare_word(input int addr, input logic [FW-1:0] expected,
                              input logic [FW-1:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error at %0t: addr %0d expected %h got %h", $time, addr, expected, actual);
    end
  endtask

  task automatic send_entry(input int i);
    rx_valid = 1'b0;
    repeat (gap_tab[i]) begin
      step_cycle();
    end
    rx_valid = 1'b1;
    rx_data  = word_tab[i];
    step_cycle();
    rx_valid = 1'b0;
  endtask

  task automatic arm_both();
    arm_a = 1'b1;
    arm_b = 1'b1;
    step_cycle();
    arm_a     = 1'b0;
    arm_b     = 1'b0;
    armed_a   = 1'b1;
    armed_b   = 1'b1;
    offered_a = 0;
    offered_b = 0;
    compare_flag("done_a after arm", 0, done_a);
    compare_flag("done_b after arm", 0, done_b);
    compare_flag("overflow_a after arm", 0, overflow_a);
    compare_flag("overflow_b after arm", 0, overflow_b);
  endtask

  task automatic wait_done();
    while (!(done_a && done_b)) begin
      step_cycle();
    end
  endtask

  task automatic read_word(input int addr, output logic [FW-1:0] data);
    rd_addr = AW'(addr);
    step_cycle();
    data = rd_data;
  endtask

  task automatic check_region(input int first);
    logic [FW-1:0] got;
    for (int k = 0; k < WORDS; k++) begin
      read_word(capture_pkg::BASE_A + k, got);
      compare_word(capture_pkg::BASE_A + k, exp_a[first + k], got);
      read_word(capture_pkg::BASE_B + k, got);
      compare_word(capture_pkg::BASE_B + k, exp_b[first + k], got);
    end
  endtask

  // Stored words must match burst frames in strictly increasing order
  task automatic check_in_order(input int ch);
    logic [FW-1:0] got;
    logic [FW-1:0] want;
    int            pos;
    int            base;
    bit            found;
    pos  = BURST_FIRST;
    base = (ch == 0) ? capture_pkg::BASE_A : capture_pkg::BASE_B;
    for (int k = 0; k < WORDS; k++) begin
      read_word(base + k, got);
      found = 1'b0;
      while (!found && pos < BURST_FIRST + BURST_LEN) begin
        want  = (ch == 0) ? exp_a[pos] : exp_b[pos];
        found = (got === want);
        pos++;
      end
      check_count++;
      if (!found) begin
        error_count++;
        $display("** Error at %0t: addr %0d word %h is not a later offered frame",
                 $time, base + k, got);
      end
    end
  endtask

  initial begin
    rst_n    = 1'b0;
    adc_rst  = 1'b0;
    rx_valid = 1'b0;
    rx_data  = '0;
    arm_a    = 1'b0;
    arm_b    = 1'b0;
    rd_addr  = '0;
    build_table();

    repeat (3) begin
      step_cycle();
    end
    compare_flag("adc_status in reset", 0, adc_status);
    rst_n = 1'b1;

    // Link status trails adc_rst by one cycle
    step_cycle();
    compare_flag("adc_status idle", 1, adc_status);
    adc_rst = 1'b1;
    step_cycle();
    compare_flag("adc_status in link reset", 0, adc_status);
    adc_rst = 1'b0;
    step_cycle();
    compare_flag("adc_status after link reset", 1, adc_status);

    // Slow frames fill both regions without loss
    arm_both();
    for (int i = STORE_FIRST; i < BURST_FIRST; i++) begin
      send_entry(i);
    end
    wait_done();
    compare_flag("overflow_a", 0, overflow_a);
    compare_flag("overflow_b", 0, overflow_b);
    check_region(STORE_FIRST);

    // Back-to-back burst while the memory is shared
    arm_both();
    for (int i = BURST_FIRST; i < LINKRST_FIRST; i++) begin
      send_entry(i);
    end
    wait_done();
    compare_flag("overflow_a", offered_a - WORDS, overflow_a);
    compare_flag("overflow_b", offered_b - WORDS, overflow_b);
    check_count += 2;
    if (overflow_a == 0) begin
      error_count++;
      $display("** Error at %0t: channel A dropped no frames in the burst", $time);
    end
    if (overflow_b == 0) begin
      error_count++;
      $display("** Error at %0t: channel B dropped no frames in the burst", $time);
    end
    check_in_order(0);
    check_in_order(1);

    // Frames under link reset must not count toward a capture
    arm_both();
    adc_rst = 1'b1;
    for (int i = LINKRST_FIRST; i < RECOVER_FIRST; i++) begin
      send_entry(i);
    end
    adc_rst = 1'b0;
    repeat (SLOW_GAP) begin
      step_cycle();
    end
    compare_flag("done_a after link reset", 0, done_a);
    compare_flag("done_b after link reset", 0, done_b);
    for (int i = RECOVER_FIRST; i < TABLE_LEN; i++) begin
      send_entry(i);
    end
    wait_done();
    check_region(RECOVER_FIRST);

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/adc_capture_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dual-channel ADC capture
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module adc_capture_top (
  input  wire logic                               rx_clk,
  input  wire logic                               rst_n,
  input  wire logic                               adc_rst,
  input  wire logic                               rx_valid,
  input  wire logic [adc_pkg::RX_WIDTH-1:0]       rx_data,
  input  wire logic                               arm_a,
  input  wire logic                               arm_b,
  input  wire logic [capture_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic                                    adc_status,
  output logic                                    done_a,
  output logic                                    done_b,
  output logic      [capture_pkg::OVF_WIDTH-1:0]  overflow_a,
  output logic      [capture_pkg::OVF_WIDTH-1:0]  overflow_b,
  output logic      [adc_pkg::FRAME_WIDTH-1:0]    rd_data
);

  logic [adc_pkg::FRAME_WIDTH-1:0]    frame_a;
  logic [adc_pkg::FRAME_WIDTH-1:0]    frame_b;
  logic                               frame_valid;

  // Handshake and payload of each capture unit
  logic                               req_a;
  logic                               ack_a;
  logic [capture_pkg::ADDR_WIDTH-1:0] addr_a;
  logic [adc_pkg::FRAME_WIDTH-1:0]    data_a;
  logic                               req_b;
  logic                               ack_b;
  logic [capture_pkg::ADDR_WIDTH-1:0] addr_b;
  logic [adc_pkg::FRAME_WIDTH-1:0]    data_b;

  // Memory write port
  logic                               wr_en;
  logic [capture_pkg::ADDR_WIDTH-1:0] wr_addr;
  logic [adc_pkg::FRAME_WIDTH-1:0]    wr_data;

  adc_if u_adc_if (
    .rx_clk      (rx_clk),
    .rst_n       (rst_n),
    .adc_rst     (adc_rst),
    .rx_valid    (rx_valid),
    .rx_data     (rx_data),
    .frame_a     (frame_a),
    .frame_b     (frame_b),
    .frame_valid (frame_valid),
    .adc_status  (adc_status)
  );

  capture_unit #(.BASE_ADDR(capture_pkg::BASE_A)) u_capture_a (
    .rx_clk (rx_clk), .rst_n (rst_n), .arm (arm_a),
    .frame (frame_a), .frame_valid (frame_valid), .ack (ack_a),
    .req (req_a), .addr (addr_a), .data (data_a),
    .done (done_a), .overflow (overflow_a)
  );

  capture_unit #(.BASE_ADDR(capture_pkg::BASE_B)) u_capture_b (
    .rx_clk (rx_clk), .rst_n (rst_n), .arm (arm_b),
    .frame (frame_b), .frame_valid (frame_valid), .ack (ack_b),
    .req (req_b), .addr (addr_b), .data (data_b),
    .done (done_b), .overflow (overflow_b)
  );

  mem_arbiter u_mem_arbiter (
    .rx_clk (rx_clk), .rst_n (rst_n),
    .req_a (req_a), .addr_a (addr_a), .data_a (data_a),
    .req_b (req_b), .addr_b (addr_b), .data_b (data_b),
    .ack_a (ack_a), .ack_b (ack_b),
    .wr_en (wr_en), .wr_addr (wr_addr), .wr_data (wr_data)
  );

  sample_ram u_sample_ram (
    .rx_clk  (rx_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

/* src/sample_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Capture sample memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module sample_ram (
  input  wire logic                               rx_clk,
  input  wire logic                               wr_en,
  input  wire logic [capture_pkg::ADDR_WIDTH-1:0] wr_addr,
  input  wire logic [adc_pkg::FRAME_WIDTH-1:0]    wr_data,
  input  wire logic [capture_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic      [adc_pkg::FRAME_WIDTH-1:0]    rd_data
);

  logic [adc_pkg::FRAME_WIDTH-1:0] mem [capture_pkg::RAM_DEPTH];

  always_ff @(posedge rx_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, data one cycle after the address
  always_ff @(posedge rx_clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* capture/mem_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sample memory write arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  wire logic                               rx_clk,
  input  wire logic                               rst_n,
  input  wire logic                               req_a,
  input  wire logic [capture_pkg::ADDR_WIDTH-1:0] addr_a,
  input  wire logic [adc_pkg::FRAME_WIDTH-1:0]    data_a,
  input  wire logic                               req_b,
  input  wire logic [capture_pkg::ADDR_WIDTH-1:0] addr_b,
  input  wire logic [adc_pkg::FRAME_WIDTH-1:0]    data_b,
  output logic                                    ack_a,
  output logic                                    ack_b,
  output logic                                    wr_en,
  output logic      [capture_pkg::ADDR_WIDTH-1:0] wr_addr,
  output logic      [adc_pkg::FRAME_WIDTH-1:0]    wr_data
);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_GRANT_A,
    ARB_GRANT_B
  } arb_state_t;

  arb_state_t state;
  logic       last_b;
  logic       grant_b;

  // Round robin, B wins a tie only if A was served last
  assign grant_b = req_b & (~req_a | ~last_b);

  always_ff @(posedge rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= ARB_IDLE;
      last_b <= 1'b0;
      ack_a  <= 1'b0;
      ack_b  <= 1'b0;
      wr_en  <= 1'b0;
    end else begin
      // Single-cycle write strobe alongside the rising ack
      wr_en <= 1'b0;
      case (state)
        ARB_IDLE: begin
          if (grant_b) begin
            state <= ARB_GRANT_B;
            ack_b <= 1'b1;
            wr_en <= 1'b1;
          end else if (req_a) begin
            state <= ARB_GRANT_A;
            ack_a <= 1'b1;
            wr_en <= 1'b1;
          end
        end
        ARB_GRANT_A: begin
          if (!req_a) begin
            state  <= ARB_IDLE;
            ack_a  <= 1'b0;
            last_b <= 1'b0;
          end
        end
        ARB_GRANT_B: begin
          if (!req_b) begin
            state  <= ARB_IDLE;
            ack_b  <= 1'b0;
            last_b <= 1'b1;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // Write address and data captured with the grant
  always_ff @(posedge rx_clk) begin
    if (state == ARB_IDLE) begin
      wr_addr <= grant_b ? addr_b : addr_a;
      wr_data <= grant_b ? data_b : data_a;
    end
  end

endmodule

`default_nettype wire

/* capture/capture_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Channel capture engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module capture_unit #(
  parameter logic [capture_pkg::ADDR_WIDTH-1:0] BASE_ADDR = '0
) (
  input  wire logic                               rx_clk,
  input  wire logic                               rst_n,
  input  wire logic                               arm,
  input  wire logic [adc_pkg::FRAME_WIDTH-1:0]    frame,
  input  wire logic                               frame_valid,
  input  wire logic                               ack,
  output logic                                    req,
  output logic      [capture_pkg::ADDR_WIDTH-1:0] addr,
  output logic      [adc_pkg::FRAME_WIDTH-1:0]    data,
  output logic                                    done,
  output logic      [capture_pkg::OVF_WIDTH-1:0]  overflow
);

  logic                                hold_full;
  logic [adc_pkg::FRAME_WIDTH-1:0]     hold_data;
  logic                                armed;
  logic                                wait_low;
  logic [capture_pkg::COUNT_WIDTH-1:0] count;
  logic                                load;
  logic                                drop;
  logic                                hs_done;

  assign load    = armed & frame_valid & ~hold_full;
  assign drop    = armed & frame_valid & hold_full;
  // Phase 2 seen, the write has landed
  assign hs_done = req & ack;

  // One-frame holding register
  always_ff @(posedge rx_clk) begin
    if (load) begin
      hold_data <= frame;
    end
  end

  always_ff @(posedge rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_full <= 1'b0;
    end else if (hs_done) begin
      hold_full <= 1'b0;
    end else if (load) begin
      hold_full <= 1'b1;
    end
  end

  // Requester side of the four-phase handshake
  always_ff @(posedge rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      req      <= 1'b0;
      wait_low <= 1'b0;
    end else if (req) begin
      if (ack) begin
        req      <= 1'b0;
        wait_low <= 1'b1;
      end
    end else begin
      if (!ack) begin
        wait_low <= 1'b0;
      end
      // No new request until the previous ack has gone low
      if ((!wait_low || !ack) && (hold_full || load)) begin
        req <= 1'b1;
      end
    end
  end

  // Word count, arm state and done flag
  always_ff @(posedge rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      armed <= 1'b0;
      done  <= 1'b0;
      count <= '0;
    end else if (arm) begin
      armed <= 1'b1;
      done  <= 1'b0;
      count <= '0;
    end else if (hs_done) begin
      count <= count + 1'b1;
      if (count == capture_pkg::COUNT_WIDTH'(capture_pkg::CAPTURE_WORDS - 1)) begin
        armed <= 1'b0;
        done  <= 1'b1;
      end
    end
  end

  // Saturating count of frames lost to a full holding register
  always_ff @(posedge rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow <= '0;
    end else if (arm) begin
      overflow <= '0;
    end else if (drop && (overflow != '1)) begin
      overflow <= overflow + 1'b1;
    end
  end

  assign addr = BASE_ADDR + capture_pkg::ADDR_WIDTH'(count);
  assign data = hold_data;

endmodule

`default_nettype wire

/* src/adc_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ADC link interface
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module adc_if (
  input  wire logic                             rx_clk,
  input  wire logic                             rst_n,
  input  wire logic                             adc_rst,
  input  wire logic                             rx_valid,
  input  wire logic [adc_pkg::RX_WIDTH-1:0]     rx_data,
  output logic      [adc_pkg::FRAME_WIDTH-1:0]  frame_a,
  output logic      [adc_pkg::FRAME_WIDTH-1:0]  frame_b,
  output logic                                  frame_valid,
  output logic                                  adc_status
);

  logic [adc_pkg::FRAME_WIDTH-1:0] unpacked [adc_pkg::NUM_CHANNELS];
  logic                            valid_q;

  // Lane slicing, sample 0 in the low bits of each frame
  always_comb begin
    for (int ch = 0; ch < adc_pkg::NUM_CHANNELS; ch++) begin
      for (int s = 0; s < adc_pkg::SAMPLES_PER_FRAME; s++) begin
        unpacked[ch][s*adc_pkg::SAMPLE_WIDTH +: adc_pkg::SAMPLE_WIDTH] = {
          rx_data[ch*adc_pkg::GROUP_WIDTH + s*adc_pkg::LANE_WIDTH +: adc_pkg::MSB_BITS],
          rx_data[ch*adc_pkg::GROUP_WIDTH + adc_pkg::HALF_WIDTH + s*adc_pkg::LANE_WIDTH
                  + adc_pkg::LANE_WIDTH - adc_pkg::LSB_BITS +: adc_pkg::LSB_BITS]
        };
      end
    end
  end

  // Frame payload follows the link word every cycle
  always_ff @(posedge rx_clk) begin
    frame_a <= unpacked[0];
    frame_b <= unpacked[1];
  end

  always_ff @(posedge rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q    <= 1'b0;
      adc_status <= 1'b0;
    end else begin
      // Words taken during a link reset never become frames
      valid_q    <= rx_valid & ~adc_rst;
      adc_status <= ~adc_rst;
    end
  end

  // Also blank the frame already in the register once link reset rises
  assign frame_valid = valid_q & ~adc_rst;

endmodule

`default_nettype wire

/* common/capture_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Capture memory layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package capture_pkg;

  // Frames stored per channel on each arm
  localparam int unsigned CAPTURE_WORDS = 8;

  // Word counter inside one region
  localparam int unsigned COUNT_WIDTH = $clog2(CAPTURE_WORDS);

  // Address covers both channel regions
  localparam int unsigned ADDR_WIDTH = 4;
  localparam int unsigned RAM_DEPTH  = 2 ** ADDR_WIDTH;

  // Region start addresses
  localparam logic [ADDR_WIDTH-1:0] BASE_A = 4'd0;
  localparam logic [ADDR_WIDTH-1:0] BASE_B = 4'd8;

  // Dropped-frame counters saturate at this width
  localparam int unsigned OVF_WIDTH = 8;

endpackage

`default_nettype wire

/* common/adc_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Converter link widths and lane slicing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package adc_pkg;

  // One link word per rx_clk cycle
  localparam int unsigned RX_WIDTH = 128;

  // Converter sample and frame geometry
  localparam int unsigned SAMPLE_WIDTH      = 14;
  localparam int unsigned SAMPLES_PER_FRAME = 4;
  localparam int unsigned FRAME_WIDTH       = SAMPLE_WIDTH * SAMPLES_PER_FRAME;

  // Two channels share the link word, each owns one group
  localparam int unsigned NUM_CHANNELS = 2;
  localparam int unsigned GROUP_WIDTH  = RX_WIDTH / NUM_CHANNELS;

  // Each group splits into a high-byte half and a low-bits half
  localparam int unsigned HALF_WIDTH = GROUP_WIDTH / 2;

  // Byte lanes inside a half, one lane per sample
  localparam int unsigned LANE_WIDTH = 8;

  // Sample = full byte from the low half, then top bits of the
  // matching byte in the upper half
  localparam int unsigned MSB_BITS = LANE_WIDTH;
  localparam int unsigned LSB_BITS = SAMPLE_WIDTH - MSB_BITS;

endpackage

`default_nettype wire
